// File: logic/dcache_pipe.sv
`timescale 1ns/1ns

module dcache_pipe import dcache_pkg::*; #(
    parameter int unsigned WAY_NUM    = 2,
    parameter int unsigned SET_NUM    = 16,
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned SB_SIZE    = 4
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         flush_i,
    input  logic                                         req_valid_i,
    input  lsu_req_t                                     req_i,
    output logic                                         req_ready_o,
    output logic                                         resp_valid_o,
    output lsu_resp_t                                    resp_o,
    input  logic                                         resp_ready_i,
    output logic                                         rd_en_o,
    output logic [$clog2(SET_NUM)-1:0]                   tag_addr_o,
    output logic [$clog2(SET_NUM*LINE_WORDS)-1:0]        data_addr_o,
    input  cache_tag_t [WAY_NUM-1:0]                     tags_i,
    input  logic [WAY_NUM-1:0][31:0]                     words_i,
    input  sb_entry_t [SB_SIZE-1:0]                      sb_entries_i,
    input  logic [SB_SIZE-1:0][$clog2(SB_SIZE)-1:0]      sb_age_i,
    output logic                                         sb_push_valid_o,
    output sb_entry_t                                    sb_push_o,
    input  logic                                         sb_push_ready_i
);
    localparam int unsigned SET_W  = $clog2(SET_NUM);
    localparam int unsigned WORD_W = $clog2(LINE_WORDS);
    localparam int unsigned AGE_W  = $clog2(SB_SIZE);

    lsu_req_t                m1_req_q;
    logic                    m1_valid_q;
    logic                    m1_store;
    logic                    accept;
    logic                    resp_fire;
    logic [WAY_NUM-1:0]      way_hit;
    logic [31:0]             way_word;
    logic [3:0]              fwd_hit;
    logic [3:0][AGE_W-1:0]   fwd_age;
    logic [31:0]             fwd_data;
    logic [31:0]             merged;
    logic [3:0]              byte_cov;
    logic [1:0]              low_byte;
    logic [31:0]             shifted;
    logic [31:0]             load_data;
    logic [3:0]              size_mask;

    assign m1_store = |m1_req_q.strb;

    // a store in M1 waits for room in the store buffer
    assign resp_valid_o = m1_valid_q & !flush_i & (!m1_store | sb_push_ready_i);
    assign resp_fire    = resp_valid_o & resp_ready_i;
    assign req_ready_o  = !flush_i & (!m1_valid_q | resp_fire);
    assign accept       = req_valid_i & req_ready_o;

    // M0 read of both ways
    assign rd_en_o     = accept;
    assign tag_addr_o  = SET_W'(addr_set(req_i.vaddr, LINE_WORDS, SET_NUM));
    assign data_addr_o = {tag_addr_o, WORD_W'(addr_word(req_i.vaddr, LINE_WORDS))};

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            m1_valid_q <= 1'b0;
        end else if (accept || resp_fire) begin
            m1_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m1_req_q <= req_i;
        end
    end

    // M1 tag compare
    always_comb begin
        way_word = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            way_hit[w] = tags_i[w].valid &&
                (tags_i[w].tag == addr_tag(m1_req_q.vaddr, LINE_WORDS, SET_NUM));
            if (way_hit[w]) begin
                way_word |= words_i[w];
            end
        end
    end

    // per byte, the youngest matching store wins
    always_comb begin
        fwd_hit  = '0;
        fwd_age  = '0;
        fwd_data = '0;
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < SB_SIZE; i++) begin
                if (sb_entries_i[i].valid && sb_entries_i[i].strb[b] &&
                    sb_entries_i[i].addr[31:2] == m1_req_q.vaddr[31:2] &&
                    (!fwd_hit[b] || sb_age_i[i] > fwd_age[b])) begin
                    fwd_hit[b]        = 1'b1;
                    fwd_age[b]        = sb_age_i[i];
                    fwd_data[8*b +: 8] = sb_entries_i[i].data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_hit[b] ? fwd_data[8*b +: 8] : way_word[8*b +: 8];
            byte_cov[b]      = fwd_hit[b] | (|way_hit);
        end
    end

    // align to the lowest requested byte, then extend
    always_comb begin
        low_byte = 2'd0;
        for (int b = 3; b >= 0; b--) begin
            if (m1_req_q.rmask[b]) begin
                low_byte = 2'(b);
            end
        end
        shifted = merged >> {low_byte, 3'b000};
        case (m1_req_q.msize)
            2'd0: begin
                load_data = {{24{m1_req_q.msigned & shifted[7]}}, shifted[7:0]};
                size_mask = 4'b0001;
            end
            2'd1: begin
                load_data = {{16{m1_req_q.msigned & shifted[15]}}, shifted[15:0]};
                size_mask = 4'b0011;
            end
            default: begin
                load_data = shifted;
                size_mask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        resp_o.hit   = m1_store ? (|way_hit)
                                : ((m1_req_q.rmask & byte_cov) == m1_req_q.rmask);
        resp_o.rdata = load_data;
        resp_o.paddr = m1_req_q.vaddr;
        resp_o.wid   = m1_req_q.wid;
    end

    // store enters the buffer as its response is taken
    assign sb_push_valid_o   = resp_fire & m1_store;
    assign sb_push_o.valid   = 1'b1;
    assign sb_push_o.addr    = m1_req_q.vaddr;
    assign sb_push_o.data    = m1_req_q.wdata;
    assign sb_push_o.strb    = m1_req_q.strb;
    assign sb_push_o.way_hit = 2'(way_hit);

    a_rmask_shape: assert property (@(posedge clk) disable iff (!rst_n)
        (m1_valid_q && !m1_store) |-> (m1_req_q.rmask == (size_mask << low_byte)));

endmodule

// File: logic/dcache_pkg.sv
package dcache_pkg;

    // one cpu memory request, strb != 0 marks a store
    typedef struct packed {
        logic [31:0] vaddr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [3:0]  rmask;
        logic [1:0]  msize;
        logic        msigned;
        logic [3:0]  wid;
    } lsu_req_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] rdata;
        logic [31:0] paddr;
        logic [3:0]  wid;
    } lsu_resp_t;

    // tag holds address bits 31..8
    typedef struct packed {
        logic        valid;
        logic        dirty;
        logic [23:0] tag;
    } cache_tag_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  way_hit;
    } sb_entry_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [1:0]  way_sel;
        logic        tag_we;
        cache_tag_t  tag_data;
        logic [3:0]  strb;
        logic [31:0] data;
        logic        fetch_sb;
    } commit_req_t;

    typedef struct packed {
        sb_entry_t sb_head;
        logic      sb_head_valid;
    } commit_resp_t;

    // address slicing, word offset sits above the 2 byte bits
    function automatic logic [31:0] addr_set(input logic [31:0] addr,
                                             input int unsigned line_words,
                                             input int unsigned set_num);
        return (addr >> (2 + $clog2(line_words))) & (set_num - 1);
    endfunction

    function automatic logic [31:0] addr_word(input logic [31:0] addr,
                                              input int unsigned line_words);
        return (addr >> 2) & (line_words - 1);
    endfunction

    function automatic logic [23:0] addr_tag(input logic [31:0] addr,
                                             input int unsigned line_words,
                                             input int unsigned set_num);
        return 24'(addr >> (2 + $clog2(line_words) + $clog2(set_num)));
    endfunction

endpackage

// File: logic/dpsram.sv
`timescale 1ns/1ns

module dpsram #(
    parameter type         T     = logic [31:0],
    parameter int unsigned DEPTH = 16,
    parameter int unsigned LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // port 0 reads only
    input  logic [$clog2(DEPTH)-1:0] addr0_i,
    input  logic                     en0_i,
    output T                         rdata0_o,
    // port 1 always reads, write-first
    input  logic [$clog2(DEPTH)-1:0] addr1_i,
    input  logic [LANES-1:0]         we1_i,
    input  T                         wdata1_i,
    output T                         rdata1_o
);
    localparam int unsigned WIDTH  = $bits(T);
    localparam int unsigned LANE_W = WIDTH / LANES;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] merged;
    logic [WIDTH-1:0] rdata0_q;
    logic [WIDTH-1:0] rdata1_q;

    // old word with the written lanes replaced
    always_comb begin
        merged = mem[addr1_i];
        for (int l = 0; l < LANES; l++) begin
            if (we1_i[l]) begin
                merged[l*LANE_W +: LANE_W] = wdata1_i[l*LANE_W +: LANE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|we1_i) begin
            mem[addr1_i] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata0_q <= '0;
            rdata1_q <= '0;
        end else begin
            if (en0_i) begin
                rdata0_q <= mem[addr0_i];
            end
            rdata1_q <= merged;
        end
    end

    assign rdata0_o = T'(rdata0_q);
    assign rdata1_o = T'(rdata1_q);

    a_lane_split: assert property (@(posedge clk) disable iff (!rst_n)
        (WIDTH % LANES) == 0);

endmodule

// File: logic/lsu_dcache.sv
`timescale 1ns/1ns

module lsu_dcache import dcache_pkg::*; #(
    parameter int unsigned WAY_NUM    = 2,
    parameter int unsigned SET_NUM    = 16,
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned SB_SIZE    = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush_i,
    input  logic         req_valid_i,
    input  lsu_req_t     req_i,
    output logic         req_ready_o,
    output logic         resp_valid_o,
    output lsu_resp_t    resp_o,
    input  logic         resp_ready_i,
    input  commit_req_t  commit_i,
    output commit_resp_t commit_o
);
    localparam int unsigned SET_W  = $clog2(SET_NUM);
    localparam int unsigned WORD_W = $clog2(LINE_WORDS);

    logic                                  rd_en;
    logic                                  rd_q;
    logic [SET_W-1:0]                      tag_addr;
    logic [SET_W+WORD_W-1:0]               data_addr;
    logic [SET_W-1:0]                      commit_set;
    logic [SET_W+WORD_W-1:0]               commit_widx;
    cache_tag_t [WAY_NUM-1:0]              tags;
    logic [WAY_NUM-1:0][31:0]              words;
    sb_entry_t [SB_SIZE-1:0]               sb_entries;
    logic [SB_SIZE-1:0][$clog2(SB_SIZE)-1:0] sb_age;
    logic                                  sb_push_valid;
    sb_entry_t                             sb_push;
    logic                                  sb_push_ready;

    assign commit_set  = SET_W'(addr_set(commit_i.addr, LINE_WORDS, SET_NUM));
    assign commit_widx = {commit_set, WORD_W'(addr_word(commit_i.addr, LINE_WORDS))};

    // M1 sees fresh SRAM data only in the cycle after a read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= rd_en;
        end
    end

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        cache_tag_t  rtag0, rtag1, tag_hold_q;
        logic [31:0] rword0, rword1, word_hold_q;
        logic        tag_conf, tag_conf_q;
        logic        data_conf, data_conf_q;

        // same row on both ports, take the write-first port 1 result
        assign tag_conf  = rd_en & (tag_addr == commit_set);
        assign data_conf = rd_en & (data_addr == commit_widx);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tag_conf_q  <= 1'b0;
                data_conf_q <= 1'b0;
            end else if (rd_en) begin
                tag_conf_q  <= tag_conf;
                data_conf_q <= data_conf;
            end
        end

        // port 1 keeps moving under a stall, so keep the bypassed value
        always_ff @(posedge clk) begin
            tag_hold_q  <= tags[w];
            word_hold_q <= words[w];
        end

        assign tags[w]  = tag_conf_q ? (rd_q ? rtag1 : tag_hold_q) : rtag0;
        assign words[w] = data_conf_q ? (rd_q ? rword1 : word_hold_q) : rword0;

        dpsram #(
            .T     (cache_tag_t),
            .DEPTH (SET_NUM),
            .LANES (1)
        ) i_tag_sram (
            .clk      (clk),
            .rst_n    (rst_n),
            .addr0_i  (tag_addr),
            .en0_i    (rd_en & !tag_conf),
            .rdata0_o (rtag0),
            .addr1_i  (commit_set),
            .we1_i    (commit_i.way_sel[w] & commit_i.tag_we),
            .wdata1_i (commit_i.tag_data),
            .rdata1_o (rtag1)
        );

        dpsram #(
            .T     (logic [31:0]),
            .DEPTH (SET_NUM * LINE_WORDS),
            .LANES (4)
        ) i_data_sram (
            .clk      (clk),
            .rst_n    (rst_n),
            .addr0_i  (data_addr),
            .en0_i    (rd_en & !data_conf),
            .rdata0_o (rword0),
            .addr1_i  (commit_widx),
            .we1_i    ({4{commit_i.way_sel[w]}} & commit_i.strb),
            .wdata1_i (commit_i.data),
            .rdata1_o (rword1)
        );
    end

    dcache_pipe #(
        .WAY_NUM    (WAY_NUM),
        .SET_NUM    (SET_NUM),
        .LINE_WORDS (LINE_WORDS),
        .SB_SIZE    (SB_SIZE)
    ) i_dcache_pipe (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .resp_valid_o    (resp_valid_o),
        .resp_o          (resp_o),
        .resp_ready_i    (resp_ready_i),
        .rd_en_o         (rd_en),
        .tag_addr_o      (tag_addr),
        .data_addr_o     (data_addr),
        .tags_i          (tags),
        .words_i         (words),
        .sb_entries_i    (sb_entries),
        .sb_age_i        (sb_age),
        .sb_push_valid_o (sb_push_valid),
        .sb_push_o       (sb_push),
        .sb_push_ready_i (sb_push_ready)
    );

    store_buffer #(
        .SB_SIZE (SB_SIZE)
    ) i_store_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .push_valid_i (sb_push_valid),
        .push_entry_i (sb_push),
        .push_ready_o (sb_push_ready),
        .entries_o    (sb_entries),
        .head_o       (commit_o.sb_head),
        .head_valid_o (commit_o.sb_head_valid),
        .pop_i        (commit_i.fetch_sb),
        .age_o        (sb_age)
    );

endmodule

// File: logic/store_buffer.sv
`timescale 1ns/1ns

module store_buffer import dcache_pkg::*; #(
    parameter int unsigned SB_SIZE = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush_i,
    input  logic                                    push_valid_i,
    input  sb_entry_t                               push_entry_i,
    output logic                                    push_ready_o,
    output sb_entry_t [SB_SIZE-1:0]                 entries_o,
    output sb_entry_t                               head_o,
    output logic                                    head_valid_o,
    input  logic                                    pop_i,
    output logic [SB_SIZE-1:0][$clog2(SB_SIZE)-1:0] age_o
);
    localparam int unsigned PTR_W = $clog2(SB_SIZE);
    localparam int unsigned CNT_W = $clog2(SB_SIZE + 1);

    sb_entry_t [SB_SIZE-1:0] entries_q;
    logic [PTR_W-1:0]        head_q;
    logic [PTR_W-1:0]        tail_q;
    logic [CNT_W-1:0]        count_q;
    logic                    do_push;
    logic                    do_pop;

    assign push_ready_o = (count_q != CNT_W'(SB_SIZE));
    assign head_valid_o = (count_q != '0);
    assign do_push      = push_valid_i & push_ready_o;
    assign do_pop       = pop_i & head_valid_o;
    assign head_o       = entries_q[head_q];
    assign entries_o    = entries_q;

    // rank 0 is the oldest entry, the highest rank the youngest
    always_comb begin
        for (int i = 0; i < SB_SIZE; i++) begin
            if (PTR_W'(i) >= head_q) begin
                age_o[i] = PTR_W'(i) - head_q;
            end else begin
                age_o[i] = PTR_W'(i + SB_SIZE) - head_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < SB_SIZE; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else begin
            if (do_push) begin
                entries_q[tail_q]       <= push_entry_i;
                entries_q[tail_q].valid <= 1'b1;
                tail_q <= (tail_q == PTR_W'(SB_SIZE - 1)) ? '0 : tail_q + 1'b1;
            end
            if (do_pop) begin
                entries_q[head_q].valid <= 1'b0;
                head_q <= (head_q == PTR_W'(SB_SIZE - 1)) ? '0 : head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // commit must only retire a store that is present
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
        pop_i |-> head_valid_o);

    // the pipeline holds stores in M1 while the buffer is full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
        push_valid_i |-> push_ready_o);

endmodule

// File: lsu_dcache.f
logic/dcache_pkg.sv
logic/dpsram.sv
logic/store_buffer.sv
logic/dcache_pipe.sv
logic/lsu_dcache.sv
testbench/tb_lsu_dcache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lsu_dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f lsu_dcache.f \
    --top-module tb_lsu_dcache \
    -o sim_tb_lsu_dcache

out=$(./obj_dir/sim_tb_lsu_dcache)
echo "$out"
echo "$out" | grep -q "STATUS: PASS"

// File: testbench/dcache_trace.txt
# op addr data mask size signed hit expected, all hex
# install mask is way_sel, store mask is strb, load mask is rmask, pop gives addr data strb
install 00001004 11223344 1 0 0 0 00000000
install 00002004 a5b6c7d8 2 0 0 0 00000000
install 00001008 cafef00d 1 0 0 0 00000000
load 00001004 00000000 f 2 0 1 11223344
load 00002004 00000000 f 2 0 1 a5b6c7d8
load 00003004 00000000 f 2 0 0 00000000
load 00002007 00000000 8 0 1 1 ffffffa5
load 00002006 00000000 4 0 0 1 000000b6
load 00002006 00000000 c 1 1 1 ffffa5b6
load 00001004 00000000 3 1 1 1 00003344
load 00002005 00000000 2 0 1 1 ffffffc7
store 00001004 000000ee 1 0 0 1 00000000
load 00001004 00000000 f 2 0 1 112233ee
store 00001004 0000aa00 2 0 0 1 00000000
load 00001004 00000000 f 2 0 1 1122aaee
store 00001004 0000bb55 3 0 0 1 00000000
load 00001004 00000000 f 2 0 1 1122bb55
store 00005008 12345678 f 0 0 0 00000000
load 00005008 00000000 f 2 0 1 12345678
load 0000500a 00000000 c 1 0 1 00001234
block 00001008 00000099 1 0 0 1 00000000
pop 00001004 0000aa00 2 0 0 0 00000000
pop 00001004 0000bb55 3 0 0 0 00000000
install 00001004 1122bb55 1 0 0 0 00000000
load 00001004 00000000 f 2 0 1 1122bb55
pop 00005008 12345678 f 0 0 0 00000000
load 00001008 00000000 f 2 0 1 cafef099
flush 00000000 00000000 0 0 0 0 00000000
load 00001008 00000000 f 2 0 1 cafef00d
load 00001004 00000000 f 2 0 1 1122bb55

// File: testbench/tb_lsu_dcache.sv
`timescale 1ns/1ns

module tb_lsu_dcache import dcache_pkg::*; ();
    logic         clk;
    logic         rst_n;
    logic         flush_i;
    logic         req_valid_i;
    lsu_req_t     req_i;
    logic         req_ready_o;
    logic         resp_valid_o;
    lsu_resp_t    resp_o;
    logic         resp_ready_i;
    commit_req_t  commit_i;
    commit_resp_t commit_o;

    logic [15:0] lfsr;
    int          errors;
    int          tests;
    int          failed_tests;
    bit          aborted;
    logic [3:0]  wid_cnt;

    // installed tag per way and set, valid bit on top
    logic [24:0] tag_model [2][16];
    // expected way_hit of each store still in the buffer, oldest first
    logic [1:0]  way_q [$];

    lsu_dcache #(
        .WAY_NUM    (2),
        .SET_NUM    (16),
        .LINE_WORDS (4),
        .SB_SIZE    (4)
    ) i_lsu_dcache (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i),
        .commit_i     (commit_i),
        .commit_o     (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // set index is address bits 7..4, tag is bits 31..8
    function automatic logic [1:0] model_way_hit(input logic [31:0] addr);
        logic [1:0] hits;
        for (int w = 0; w < 2; w++) begin
            hits[w] = (tag_model[w][addr[7:4]] == {1'b1, addr[31:8]});
        end
        return hits;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %0s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic commit_pulse(input commit_req_t c);
        @(posedge clk);
        commit_i <= c;
        @(posedge clk);
        commit_i <= '0;
    endtask

    task automatic send_req(input lsu_req_t r);
        int n;
        @(posedge clk);
        req_i       <= r;
        req_valid_i <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!req_ready_o && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready_o) begin
            $display("timeout: request at %h was never accepted", r.vaddr);
            aborted = 1'b1;
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
    endtask

    // random back-pressure while the response is pending
    task automatic get_resp(output lsu_resp_t r);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        lfsr = lfsr_next(lfsr);
        resp_ready_i <= lfsr[0];
        while (!seen && n < 100) begin
            @(negedge clk);
            if (resp_valid_o && resp_ready_i) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                lfsr = lfsr_next(lfsr);
                resp_ready_i <= lfsr[0];
                n++;
            end
        end
        r = resp_o;
        if (!seen) begin
            $display("timeout: no response arrived");
            aborted = 1'b1;
        end
        @(posedge clk);
        resp_ready_i <= 1'b0;
    endtask

    initial begin
        int          fd;
        int          err_before;
        string       line;
        logic [63:0] op;
        logic [31:0] a, d, m, z, g, h, e;
        logic [1:0]  exp_way;
        lsu_req_t    r;
        lsu_resp_t   rs;
        commit_req_t c;

        rst_n = 1'b0;
        flush_i = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        resp_ready_i = 1'b0;
        commit_i = '0;
        lfsr = 16'd10;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        aborted = 1'b0;
        wid_cnt = '0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 16; s++) begin
                tag_model[w][s] = '0;
            end
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("testbench/dcache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 4 || line[0] == "#") begin
                continue;
            end
            void'($sscanf(line, "%s %h %h %h %h %h %h %h", op, a, d, m, z, g, h, e));
            err_before = errors;
            tests++;
            if (op == "install") begin
                c = '0;
                c.addr = a;
                c.way_sel = m[1:0];
                c.tag_we = 1'b1;
                c.tag_data = {1'b1, 1'b0, a[31:8]};
                c.strb = 4'hf;
                c.data = d;
                commit_pulse(c);
                for (int w = 0; w < 2; w++) begin
                    if (m[w]) begin
                        tag_model[w][a[7:4]] = {1'b1, a[31:8]};
                    end
                end
            end else if (op == "store" || op == "load" || op == "block") begin
                r = '0;
                r.vaddr = a;
                r.wdata = d;
                r.strb = (op == "load") ? 4'h0 : m[3:0];
                r.rmask = (op == "load") ? m[3:0] : 4'h0;
                r.msize = z[1:0];
                r.msigned = g[0];
                r.wid = wid_cnt;
                if (op != "load") begin
                    way_q.push_back(model_way_hit(a));
                end
                send_req(r);
                if (op == "block") begin
                    // store must stall in M1 while the buffer is full
                    repeat (5) begin
                        @(negedge clk);
                        if (resp_valid_o || req_ready_o) begin
                            $display("store went through while the store buffer was full");
                            errors++;
                        end
                    end
                    c = '0;
                    c.fetch_sb = 1'b1;
                    commit_pulse(c);
                    exp_way = way_q.pop_front();
                end
                if (!aborted) begin
                    get_resp(rs);
                end
                check_val("resp_o.hit", 32'(rs.hit), h);
                check_val("resp_o.wid", 32'(rs.wid), 32'(wid_cnt));
                check_val("resp_o.paddr", rs.paddr, a);
                if (op == "load" && h[0]) begin
                    check_val("resp_o.rdata", rs.rdata, e);
                end
                wid_cnt++;
            end else if (op == "pop") begin
                @(negedge clk);
                check_val("sb_head_valid", 32'(commit_o.sb_head_valid), 32'd1);
                check_val("sb_head.valid", 32'(commit_o.sb_head.valid), 32'd1);
                check_val("sb_head.addr", commit_o.sb_head.addr, a);
                check_val("sb_head.data", commit_o.sb_head.data, d);
                check_val("sb_head.strb", 32'(commit_o.sb_head.strb), m);
                if (way_q.size() != 0) begin
                    exp_way = way_q.pop_front();
                    check_val("sb_head.way_hit", 32'(commit_o.sb_head.way_hit),
                              32'(exp_way));
                end else begin
                    $display("store buffer shows an entry that was never stored");
                    errors++;
                end
                c = '0;
                c.fetch_sb = 1'b1;
                commit_pulse(c);
            end else if (op == "flush") begin
                @(posedge clk);
                flush_i <= 1'b1;
                @(posedge clk);
                flush_i <= 1'b0;
                way_q.delete();
                @(negedge clk);
                check_val("sb_head_valid", 32'(commit_o.sb_head_valid), 32'd0);
            end else begin
                $display("unknown trace operation in line: %0s", line);
                errors++;
            end
            if (errors != err_before || aborted) begin
                failed_tests++;
            end
            $display("test %0d %0s %h: %0s", tests, op, a,
                     (errors == err_before && !aborted) ? "ok" : "failed");
        end
        $display("tests %0d, failed %0d, check errors %0d", tests, failed_tests, errors);
        if (errors == 0 && !aborted) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
